// ==== decode_stage.f ====
+incdir+common
common/mips_pkg.sv
hw/decode/id_regfile.sv
hw/decode/id_main_ctrl.sv
hw/decode/id_branch_unit.sv
hw/decode/id_forward_unit.sv
hw/decode/id_ex_reg.sv
hw/decode/decode_stage.sv
bench/decode_stage_assert.sv
bench/decode_stage_tb.sv

// ==== bench/decode_stage_tests.txt ====
# kind(1 early,2 registered) instr pc4 wb_we wb_addr wb_data ex_rd ex_rw ex_alures mem_rd mem_fl(rw,rd)
# then: taken jsel target rs rt imm alu_op ctrl(src,dst,mrd,mwr,m2r,rw,link) load fwd_a fwd_b
3 00222820 00400004 1 01 11111111 00 0 00000000 00 0 0 0 0040a084 11111111 00000000 00002820 00 22 0 0 0
2 00223021 00400008 1 02 22222222 00 0 00000000 00 0 0 0 00000000 11111111 22222222 00003021 01 22 0 0 0
2 00603822 0040000c 1 03 00000005 00 0 00000000 00 0 0 0 00000000 00000005 00000000 00003822 02 22 0 0 0
2 00834023 00400010 1 04 00000005 00 0 00000000 00 0 0 0 00000000 00000005 00000005 00004023 03 22 0 0 0
2 00014824 00400014 1 00 ffffffff 00 0 00000000 00 0 0 0 00000000 00000000 11111111 00004824 04 22 0 0 0
2 00225025 00400018 0 00 00000000 00 0 00000000 00 0 0 0 00000000 11111111 22222222 00005025 05 22 0 0 0
2 00225826 0040001c 0 00 00000000 00 0 00000000 00 0 0 0 00000000 11111111 22222222 00005826 06 22 0 0 0
2 00226027 00400020 0 00 00000000 00 0 00000000 00 0 0 0 00000000 11111111 22222222 00006027 07 22 0 0 0
2 0064682a 00400024 0 00 00000000 00 0 00000000 00 0 0 0 00000000 00000005 00000005 0000682a 08 22 0 0 0
2 0023702b 00400028 0 00 00000000 00 0 00000000 00 0 0 0 00000000 11111111 00000005 0000702b 09 22 0 0 0
2 2025fffc 0040002c 0 00 00000000 00 0 00000000 00 0 0 0 00000000 11111111 00000000 fffffffc 00 42 0 0 0
2 24468000 00400030 0 00 00000000 00 0 00000000 00 0 0 0 00000000 22222222 00000000 ffff8000 01 42 0 0 0
2 28670010 00400034 0 00 00000000 00 0 00000000 00 0 0 0 00000000 00000005 00000000 00000010 08 42 0 0 0
2 3028ff00 00400038 0 00 00000000 00 0 00000000 00 0 0 0 00000000 11111111 00000000 0000ff00 04 42 0 0 0
2 34498001 0040003c 0 00 00000000 00 0 00000000 00 0 0 0 00000000 22222222 00000000 00008001 05 42 0 0 0
2 386affff 00400040 0 00 00000000 00 0 00000000 00 0 0 0 00000000 00000005 00000000 0000ffff 06 42 0 0 0
2 3c0b1234 00400044 0 00 00000000 00 0 00000000 00 0 0 0 00000000 00000000 00000000 00001234 0a 42 0 0 0
2 8c2c0008 00400048 0 00 00000000 00 0 00000000 00 0 0 0 00000000 11111111 00000000 00000008 00 56 0 0 0
2 844dfffe 0040004c 0 00 00000000 00 0 00000000 00 0 0 0 00000000 22222222 00000000 fffffffe 00 56 1 0 0
2 806e0001 00400050 0 00 00000000 00 0 00000000 00 0 0 0 00000000 00000005 00000000 00000001 00 56 2 0 0
2 ac220004 00400054 0 00 00000000 00 0 00000000 00 0 0 0 00000000 11111111 22222222 00000004 00 48 0 0 0
1 10640004 00400100 0 00 00000000 00 0 00000000 00 0 1 0 00400110 00000000 00000000 00000000 00 00 0 0 0
1 1464fff8 00400200 0 00 00000000 00 0 00000000 00 0 0 0 004001e0 00000000 00000000 00000000 00 00 0 0 0
1 1022ffff 00400300 0 00 00000000 00 0 00000000 00 0 0 0 004002fc 00000000 00000000 00000000 00 00 0 0 0
1 14220010 00400400 0 00 00000000 00 0 00000000 00 0 1 0 00400440 00000000 00000000 00000000 00 00 0 0 0
3 10220002 00400500 0 00 00000000 01 1 22222222 00 0 1 0 00400508 11111111 22222222 00000002 00 00 0 1 0
1 08100040 f0000010 0 00 00000000 00 0 00000000 00 0 0 1 f0400100 00000000 00000000 00000000 00 00 0 0 0
3 0fffffff 00400600 0 00 00000000 00 0 00000000 00 0 0 1 0ffffffc 00000000 00000000 ffffffff 00 03 0 0 0
1 00200008 00400700 0 00 00000000 00 0 00000000 00 0 0 2 11111111 00000000 00000000 00000000 00 00 0 0 0
3 0040f809 00400800 0 00 00000000 02 1 00400800 00 0 0 2 00400800 22222222 00000000 fffff809 00 23 0 1 0
2 00220820 00400900 0 00 00000000 01 1 00000000 02 2 0 0 00000000 11111111 22222222 00000820 00 22 0 1 2
2 00220820 00400904 0 00 00000000 01 0 00000000 01 3 0 0 00000000 11111111 22222222 00000820 00 22 0 3 0
2 00000820 00400908 0 00 00000000 00 1 00000000 00 3 0 0 00000000 00000000 00000000 00000820 00 22 0 0 0
2 00420820 0040090c 0 00 00000000 02 1 00000000 02 2 0 0 00000000 22222222 22222222 00000820 00 22 0 1 1
2 00420820 00400910 0 00 00000000 03 1 00000000 02 1 0 0 00000000 22222222 22222222 00000820 00 22 0 0 0

// ==== bench/decode_stage_tb.sv ====
// testbench for decode_stage that replays the tests file and checks early and ID/EX outputs
`include "mips_cfg.svh"

module decode_stage_tb;

	timeunit 1ns;
	timeprecision 1ps;

	typedef struct {
		logic [31:0] kind, instr, pc4, wb_we, wb_addr, wb_data;
		logic [31:0] ex_rd, ex_rw, ex_alures, mem_rd, mem_fl;
		logic [31:0] taken, jsel, target, rs, rt, imm, alu, ctrl, ld, fwd_a, fwd_b;
	} test_t;

	test_t tests [$];
	int    num_tests;
	bit    loaded;

	logic i_clk, i_nrst, i_wb_we, i_ex_regwrite, i_mem_regwrite, i_mem_memread;
	logic [`MIPS_XLEN-1:0] i_instr, i_pc4, i_wb_data, i_ex_alures;
	logic [`MIPS_RADDR-1:0] i_wb_addr, i_ex_rd, i_mem_rd;
	logic o_branch_taken, o_alu_src, o_reg_dst, o_mem_read, o_mem_write;
	logic o_mem_to_reg, o_reg_write, o_link;
	logic [`MIPS_XLEN-1:0] o_branch_target, o_jump_target, o_rs_data, o_rt_data, o_pc4, o_imm;
	logic [`MIPS_RADDR-1:0] o_rd_addr, o_rt_addr;
	mips_pkg::jump_e   o_jump_sel;
	mips_pkg::alu_op_e o_alu_op;
	mips_pkg::load_e   o_load_width;
	mips_pkg::fwd_e    o_fwd_a, o_fwd_b;

	decode_stage dut (.*);

	bind decode_stage decode_stage_assert u_assert (.*);

	initial i_clk = 1'b0;
	always #50 i_clk = ~i_clk;

	// ==================================================
	// compare tasks
	// ==================================================
	task automatic report_mismatch(input string what, input string got, input string exp);
		$display("ERROR at %0t ns: %s is %s, expected %s", $time, what, got, exp);
		$display("Checks failed");
		$fatal(1, "mismatch on %s", what);
	endtask

	task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) report_mismatch(what, $sformatf("%h", got), $sformatf("%h", exp));
	endtask

	task automatic check_alu_op(input mips_pkg::alu_op_e got, input mips_pkg::alu_op_e exp);
		if (got !== exp) report_mismatch("o_alu_op", got.name(), exp.name());
	endtask

	task automatic check_jump(input mips_pkg::jump_e got, input mips_pkg::jump_e exp);
		if (got !== exp) report_mismatch("o_jump_sel", got.name(), exp.name());
	endtask

	task automatic check_fwd(input string what, input mips_pkg::fwd_e got,
		input mips_pkg::fwd_e exp);
		if (got !== exp) report_mismatch(what, got.name(), exp.name());
	endtask

	task automatic check_load(input mips_pkg::load_e got, input mips_pkg::load_e exp);
		if (got !== exp) report_mismatch("o_load_width", got.name(), exp.name());
	endtask

	// ==================================================
	// stimulus and expected values
	// ==================================================
	task automatic load_tests();
		int    fd;
		int    n;
		string line;
		test_t t;
		fd = $fopen("bench/decode_stage_tests.txt", "r");
		if (fd == 0) begin
			$display("could not open the tests file");
			$display("Checks failed");
			$fatal(1, "no tests file");
		end
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() < 2 || line.getc(0) == "#") continue;
			n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
				t.kind, t.instr, t.pc4, t.wb_we, t.wb_addr, t.wb_data, t.ex_rd, t.ex_rw,
				t.ex_alures, t.mem_rd, t.mem_fl, t.taken, t.jsel, t.target, t.rs, t.rt,
				t.imm, t.alu, t.ctrl, t.ld, t.fwd_a, t.fwd_b);
			if (n != 22) begin
				$display("malformed line in the tests file: %s", line);
				$display("Checks failed");
				$fatal(1, "bad tests file");
			end
			tests.push_back(t);
		end
		$fclose(fd);
	endtask

	task automatic apply_test(input test_t t);
		i_instr        = t.instr;
		i_pc4          = t.pc4;
		i_wb_we        = t.wb_we[0];
		i_wb_addr      = t.wb_addr[`MIPS_RADDR-1:0];
		i_wb_data      = t.wb_data;
		i_ex_rd        = t.ex_rd[`MIPS_RADDR-1:0];
		i_ex_regwrite  = t.ex_rw[0];
		i_ex_alures    = t.ex_alures;
		i_mem_rd       = t.mem_rd[`MIPS_RADDR-1:0];
		i_mem_regwrite = t.mem_fl[1];
		i_mem_memread  = t.mem_fl[0];
	endtask

	task automatic check_early(input test_t t);
		check_word("o_branch_taken", o_branch_taken, t.taken);
		check_jump(o_jump_sel, mips_pkg::jump_e'(t.jsel[1:0]));
		// branch target when no jump, jump target otherwise
		if (t.jsel == 0) begin
			check_word("o_branch_target", o_branch_target, t.target);
		end else begin
			check_word("o_jump_target", o_jump_target, t.target);
		end
	endtask

	task automatic check_registered(input test_t t);
		logic [6:0] ctrl;
		ctrl = {o_alu_src, o_reg_dst, o_mem_read, o_mem_write, o_mem_to_reg, o_reg_write, o_link};
		check_word("o_rs_data", o_rs_data, t.rs);
		check_word("o_rt_data", o_rt_data, t.rt);
		check_word("o_imm", o_imm, t.imm);
		check_word("o_pc4", o_pc4, t.pc4);
		check_word("o_rd_addr", o_rd_addr, t.instr[15:11]);
		check_word("o_rt_addr", o_rt_addr, t.instr[20:16]);
		check_word("control bits", ctrl, t.ctrl);
		check_alu_op(o_alu_op, mips_pkg::alu_op_e'(t.alu[5:0]));
		check_load(o_load_width, mips_pkg::load_e'(t.ld[1:0]));
		check_fwd("o_fwd_a", o_fwd_a, mips_pkg::fwd_e'(t.fwd_a[2:0]));
		check_fwd("o_fwd_b", o_fwd_b, mips_pkg::fwd_e'(t.fwd_b[2:0]));
	endtask

	task automatic check_reset_state();
		test_t zero;
		zero = '{default: '0};
		check_word("o_pc4", o_pc4, 32'h0);
		check_word("o_rd_addr", o_rd_addr, 32'h0);
		check_word("o_rt_addr", o_rt_addr, 32'h0);
		check_word("o_rs_data", o_rs_data, zero.rs);
		check_word("o_rt_data", o_rt_data, zero.rt);
		check_word("o_imm", o_imm, zero.imm);
		check_word("control bits", {o_alu_src, o_reg_dst, o_mem_read, o_mem_write,
			o_mem_to_reg, o_reg_write, o_link}, 32'h0);
		check_alu_op(o_alu_op, mips_pkg::ALU_ADD);
		check_load(o_load_width, mips_pkg::LD_WORD);
		check_fwd("o_fwd_a", o_fwd_a, mips_pkg::FWD_NONE);
		check_fwd("o_fwd_b", o_fwd_b, mips_pkg::FWD_NONE);
	endtask

	// watchdog sized from the number of tests
	initial begin
		wait (loaded);
		#((num_tests + 20) * 100);
		$display("timeout: the tests did not finish in the expected time");
		$display("Checks failed");
		$fatal(1, "timeout");
	end

	// ==================================================
	// main sequence
	// ==================================================
	initial begin
		i_nrst = 1'b0;
		apply_test('{default: '0});
		// a store with execute forwarding that only the clear keeps out of ID/EX
		i_instr       = 32'hac220004;
		i_pc4         = 32'h00400000;
		i_ex_rd       = 5'd1;
		i_ex_regwrite = 1'b1;
		load_tests();
		num_tests = tests.size();
		loaded = 1'b1;

		repeat (10) @(posedge i_clk);
		#5;
		check_reset_state();
		apply_test('{default: '0});
		i_nrst = 1'b1;

		for (int i = 0; i < num_tests; i++) begin
			@(posedge i_clk);
			#5;
			apply_test(tests[i]);
			#90;
			if (tests[i].kind[0]) check_early(tests[i]);
			if (i > 0 && tests[i-1].kind[1]) check_registered(tests[i-1]);
		end
		@(posedge i_clk);
		#5;
		apply_test('{default: '0});
		#90;
		if (tests[num_tests-1].kind[1]) check_registered(tests[num_tests-1]);

		$display("All checks passed");
		$finish;
	end

endmodule

// ==== bench/decode_stage_assert.sv ====
// control sanity assertions for the decode stage, attached to decode_stage with bind
module decode_stage_assert (
	input logic           i_clk,
	input logic           i_nrst,
	input logic           o_reg_write,
	input logic           o_mem_read,
	input logic           o_mem_write,
	input mips_pkg::fwd_e o_fwd_a
);

	timeunit 1ns;
	timeprecision 1ps;

	// reset leaves a bubble in ID/EX
	a_reset_quiet: assert property (@(posedge i_clk)
		!i_nrst |-> (!o_reg_write && !o_mem_write))
		else $error("register or memory write active during reset");

	// one memory access kind at a time
	a_mem_onehot: assert property (@(posedge i_clk) disable iff (!i_nrst)
		!(o_mem_read && o_mem_write))
		else $error("load and store flagged together");

	// only the four defined select codes
	a_fwd_a_legal: assert property (@(posedge i_clk) disable iff (!i_nrst)
		!$isunknown(o_fwd_a) && (o_fwd_a <= mips_pkg::FWD_MEM_LOAD))
		else $error("operand a forwarding select holds an undefined code");

endmodule

// ==== hw/decode/decode_stage.sv ====
// MIPS decode stage top, joins register bank, decoders, forwarding and the ID/EX register
`include "mips_cfg.svh"

module decode_stage (
	input  logic                   i_clk,
	input  logic                   i_nrst,
	input  logic [`MIPS_XLEN-1:0]  i_instr,
	input  logic [`MIPS_XLEN-1:0]  i_pc4,
	input  logic                   i_wb_we,
	input  logic [`MIPS_RADDR-1:0] i_wb_addr,
	input  logic [`MIPS_XLEN-1:0]  i_wb_data,
	input  logic [`MIPS_RADDR-1:0] i_ex_rd,
	input  logic                   i_ex_regwrite,
	input  logic [`MIPS_XLEN-1:0]  i_ex_alures,
	input  logic [`MIPS_RADDR-1:0] i_mem_rd,
	input  logic                   i_mem_regwrite,
	input  logic                   i_mem_memread,
	output logic                   o_branch_taken,
	output mips_pkg::jump_e        o_jump_sel,
	output logic [`MIPS_XLEN-1:0]  o_branch_target,
	output logic [`MIPS_XLEN-1:0]  o_jump_target,
	output logic [`MIPS_XLEN-1:0]  o_rs_data,
	output logic [`MIPS_XLEN-1:0]  o_rt_data,
	output logic [`MIPS_RADDR-1:0] o_rd_addr,
	output logic [`MIPS_RADDR-1:0] o_rt_addr,
	output logic [`MIPS_XLEN-1:0]  o_pc4,
	output logic [`MIPS_XLEN-1:0]  o_imm,
	output mips_pkg::alu_op_e      o_alu_op,
	output logic                   o_alu_src,
	output logic                   o_reg_dst,
	output logic                   o_mem_read,
	output logic                   o_mem_write,
	output mips_pkg::load_e        o_load_width,
	output logic                   o_mem_to_reg,
	output logic                   o_reg_write,
	output logic                   o_link,
	output mips_pkg::fwd_e         o_fwd_a,
	output mips_pkg::fwd_e         o_fwd_b
);

	// ================================================
	// instruction fields
	// ================================================
	mips_pkg::opcode_e     opcode;
	mips_pkg::funct_e      funct;
	logic [`MIPS_RADDR-1:0] rs_addr;
	logic [`MIPS_RADDR-1:0] rt_addr;

	assign opcode  = mips_pkg::opcode_e'(i_instr[31:26]);
	assign funct   = mips_pkg::funct_e'(i_instr[5:0]);
	assign rs_addr = i_instr[25:21];
	assign rt_addr = i_instr[20:16];

	// read data and decoded control into the pipeline register
	logic [`MIPS_XLEN-1:0] rs_data;
	logic [`MIPS_XLEN-1:0] rt_data;
	mips_pkg::alu_op_e     alu_op;
	mips_pkg::load_e       load_width;
	mips_pkg::fwd_e        fwd_a;
	mips_pkg::fwd_e        fwd_b;
	logic alu_src, reg_dst, mem_read, mem_write;
	logic mem_to_reg, reg_write, link, sign_ext, cmp_fwd;

	// ================================================
	// submodules
	// ================================================
	id_regfile u_regfile (
		.i_clk(i_clk), .i_nrst(i_nrst),
		.i_rs_addr(rs_addr), .i_rt_addr(rt_addr),
		.i_we(i_wb_we), .i_wd_addr(i_wb_addr), .i_wd_data(i_wb_data),
		.o_rs_data(rs_data), .o_rt_data(rt_data)
	);

	id_main_ctrl u_main_ctrl (
		.i_opcode(opcode), .i_funct(funct),
		.o_alu_op(alu_op), .o_alu_src(alu_src), .o_reg_dst(reg_dst),
		.o_mem_read(mem_read), .o_mem_write(mem_write), .o_load_width(load_width),
		.o_mem_to_reg(mem_to_reg), .o_reg_write(reg_write), .o_link(link),
		.o_sign_ext(sign_ext)
	);

	id_forward_unit u_forward (
		.i_rs_addr(rs_addr), .i_rt_addr(rt_addr),
		.i_ex_rd(i_ex_rd), .i_ex_regwrite(i_ex_regwrite),
		.i_mem_rd(i_mem_rd), .i_mem_regwrite(i_mem_regwrite), .i_mem_memread(i_mem_memread),
		.o_fwd_a(fwd_a), .o_fwd_b(fwd_b), .o_cmp_fwd(cmp_fwd)
	);

	// early outputs go straight to the fetch side
	id_branch_unit u_branch (
		.i_opcode(opcode), .i_funct(funct), .i_pc4(i_pc4),
		.i_imm(i_instr[15:0]), .i_index(i_instr[25:0]),
		.i_rs_data(rs_data), .i_rt_data(rt_data),
		.i_ex_alures(i_ex_alures), .i_cmp_fwd(cmp_fwd),
		.o_branch_taken(o_branch_taken), .o_jump_sel(o_jump_sel),
		.o_branch_target(o_branch_target), .o_jump_target(o_jump_target)
	);

	id_ex_reg u_id_ex (
		.i_clk(i_clk), .i_nrst(i_nrst),
		.i_rs_data(rs_data), .i_rt_data(rt_data),
		.i_rd_addr(i_instr[15:11]), .i_rt_addr(rt_addr), .i_pc4(i_pc4),
		.i_imm(i_instr[15:0]), .i_sign_ext(sign_ext),
		.i_alu_op(alu_op), .i_alu_src(alu_src), .i_reg_dst(reg_dst),
		.i_mem_read(mem_read), .i_mem_write(mem_write), .i_load_width(load_width),
		.i_mem_to_reg(mem_to_reg), .i_reg_write(reg_write), .i_link(link),
		.i_fwd_a(fwd_a), .i_fwd_b(fwd_b),
		.o_rs_data(o_rs_data), .o_rt_data(o_rt_data),
		.o_rd_addr(o_rd_addr), .o_rt_addr(o_rt_addr), .o_pc4(o_pc4), .o_imm(o_imm),
		.o_alu_op(o_alu_op), .o_alu_src(o_alu_src), .o_reg_dst(o_reg_dst),
		.o_mem_read(o_mem_read), .o_mem_write(o_mem_write), .o_load_width(o_load_width),
		.o_mem_to_reg(o_mem_to_reg), .o_reg_write(o_reg_write), .o_link(o_link),
		.o_fwd_a(o_fwd_a), .o_fwd_b(o_fwd_b)
	);

endmodule

// ==== hw/decode/id_ex_reg.sv ====
// ID/EX pipeline register, extends the immediate and holds one decoded instruction for execute
`include "mips_cfg.svh"

module id_ex_reg (
	input  logic                   i_clk,
	input  logic                   i_nrst,
	input  logic [`MIPS_XLEN-1:0]  i_rs_data,
	input  logic [`MIPS_XLEN-1:0]  i_rt_data,
	input  logic [`MIPS_RADDR-1:0] i_rd_addr,
	input  logic [`MIPS_RADDR-1:0] i_rt_addr,
	input  logic [`MIPS_XLEN-1:0]  i_pc4,
	input  logic [15:0]            i_imm,
	input  logic                   i_sign_ext,
	input  mips_pkg::alu_op_e      i_alu_op,
	input  logic                   i_alu_src,
	input  logic                   i_reg_dst,
	input  logic                   i_mem_read,
	input  logic                   i_mem_write,
	input  mips_pkg::load_e        i_load_width,
	input  logic                   i_mem_to_reg,
	input  logic                   i_reg_write,
	input  logic                   i_link,
	input  mips_pkg::fwd_e         i_fwd_a,
	input  mips_pkg::fwd_e         i_fwd_b,
	output logic [`MIPS_XLEN-1:0]  o_rs_data,
	output logic [`MIPS_XLEN-1:0]  o_rt_data,
	output logic [`MIPS_RADDR-1:0] o_rd_addr,
	output logic [`MIPS_RADDR-1:0] o_rt_addr,
	output logic [`MIPS_XLEN-1:0]  o_pc4,
	output logic [`MIPS_XLEN-1:0]  o_imm,
	output mips_pkg::alu_op_e      o_alu_op,
	output logic                   o_alu_src,
	output logic                   o_reg_dst,
	output logic                   o_mem_read,
	output logic                   o_mem_write,
	output mips_pkg::load_e        o_load_width,
	output logic                   o_mem_to_reg,
	output logic                   o_reg_write,
	output logic                   o_link,
	output mips_pkg::fwd_e         o_fwd_a,
	output mips_pkg::fwd_e         o_fwd_b
);

	logic [`MIPS_XLEN-1:0] imm_ext;

	assign imm_ext = i_sign_ext ? {{(`MIPS_XLEN-16){i_imm[15]}}, i_imm} :
		{{(`MIPS_XLEN-16){1'b0}}, i_imm};

	always_ff @(posedge i_clk or negedge i_nrst) begin
		if (!i_nrst) begin
			// bubble: no access, no write, no forwarding
			o_rs_data    <= '0;
			o_rt_data    <= '0;
			o_rd_addr    <= '0;
			o_rt_addr    <= '0;
			o_pc4        <= '0;
			o_imm        <= '0;
			o_alu_op     <= mips_pkg::ALU_ADD;
			o_alu_src    <= 1'b0;
			o_reg_dst    <= 1'b0;
			o_mem_read   <= 1'b0;
			o_mem_write  <= 1'b0;
			o_load_width <= mips_pkg::LD_WORD;
			o_mem_to_reg <= 1'b0;
			o_reg_write  <= 1'b0;
			o_link       <= 1'b0;
			o_fwd_a      <= mips_pkg::FWD_NONE;
			o_fwd_b      <= mips_pkg::FWD_NONE;
		end else begin
			o_rs_data    <= i_rs_data;
			o_rt_data    <= i_rt_data;
			o_rd_addr    <= i_rd_addr;
			o_rt_addr    <= i_rt_addr;
			o_pc4        <= i_pc4;
			o_imm        <= imm_ext;
			o_alu_op     <= i_alu_op;
			o_alu_src    <= i_alu_src;
			o_reg_dst    <= i_reg_dst;
			o_mem_read   <= i_mem_read;
			o_mem_write  <= i_mem_write;
			o_load_width <= i_load_width;
			o_mem_to_reg <= i_mem_to_reg;
			o_reg_write  <= i_reg_write;
			o_link       <= i_link;
			o_fwd_a      <= i_fwd_a;
			o_fwd_b      <= i_fwd_b;
		end
	end

endmodule

// ==== hw/decode/id_forward_unit.sv ====
// operand forwarding selects for execute and the rs forwarding choice of the branch compare
`include "mips_cfg.svh"

module id_forward_unit (
	input  logic [`MIPS_RADDR-1:0] i_rs_addr,
	input  logic [`MIPS_RADDR-1:0] i_rt_addr,
	input  logic [`MIPS_RADDR-1:0] i_ex_rd,
	input  logic                   i_ex_regwrite,
	input  logic [`MIPS_RADDR-1:0] i_mem_rd,
	input  logic                   i_mem_regwrite,
	input  logic                   i_mem_memread,
	output mips_pkg::fwd_e         o_fwd_a,
	output mips_pkg::fwd_e         o_fwd_b,
	output logic                   o_cmp_fwd
);

	// priority: execute result, then memory stage, register 0 never
	function automatic mips_pkg::fwd_e fwd_select(input logic [`MIPS_RADDR-1:0] src);
		mips_pkg::fwd_e sel;
		sel = mips_pkg::FWD_NONE;
		if (src != '0) begin
			if (i_ex_regwrite && src == i_ex_rd) begin
				sel = mips_pkg::FWD_EX_ALU;
			end else if (i_mem_regwrite && src == i_mem_rd) begin
				sel = i_mem_memread ? mips_pkg::FWD_MEM_LOAD : mips_pkg::FWD_MEM_ALU;
			end
		end
		return sel;
	endfunction

	always_comb begin
		o_fwd_a = fwd_select(i_rs_addr);
		o_fwd_b = fwd_select(i_rt_addr);
	end

	// only the execute ALU result can reach the compare in time
	assign o_cmp_fwd = (i_rs_addr != '0) && i_ex_regwrite && (i_rs_addr == i_ex_rd);

endmodule

// ==== hw/decode/id_branch_unit.sv ====
// early branch and jump resolution in decode, compares operands and forms both targets
`include "mips_cfg.svh"

module id_branch_unit (
	input  mips_pkg::opcode_e     i_opcode,
	input  mips_pkg::funct_e      i_funct,
	input  logic [`MIPS_XLEN-1:0] i_pc4,
	input  logic [15:0]           i_imm,
	input  logic [25:0]           i_index,
	input  logic [`MIPS_XLEN-1:0] i_rs_data,
	input  logic [`MIPS_XLEN-1:0] i_rt_data,
	input  logic [`MIPS_XLEN-1:0] i_ex_alures,
	input  logic                  i_cmp_fwd,
	output logic                  o_branch_taken,
	output mips_pkg::jump_e       o_jump_sel,
	output logic [`MIPS_XLEN-1:0] o_branch_target,
	output logic [`MIPS_XLEN-1:0] o_jump_target
);

	mips_pkg::branch_e     br_cond;
	logic [`MIPS_XLEN-1:0] cmp_rs;
	logic [`MIPS_XLEN-1:0] br_offset;
	logic                  ops_equal;

	// branch and jump kind
	always_comb begin
		br_cond    = mips_pkg::BR_NONE;
		o_jump_sel = mips_pkg::JMP_NONE;
		case (i_opcode)
			mips_pkg::OP_BEQ: br_cond = mips_pkg::BR_EQ;
			mips_pkg::OP_BNE: br_cond = mips_pkg::BR_NE;
			mips_pkg::OP_J, mips_pkg::OP_JAL: o_jump_sel = mips_pkg::JMP_TARGET;
			mips_pkg::OP_RTYPE: begin
				if (i_funct == mips_pkg::F_JR || i_funct == mips_pkg::F_JALR) begin
					o_jump_sel = mips_pkg::JMP_REG;
				end
			end
			default: begin
			end
		endcase
	end

	// rs may still be in flight in execute
	assign cmp_rs    = i_cmp_fwd ? i_ex_alures : i_rs_data;
	assign ops_equal = (cmp_rs == i_rt_data);

	always_comb begin
		case (br_cond)
			mips_pkg::BR_EQ: o_branch_taken = ops_equal;
			mips_pkg::BR_NE: o_branch_taken = !ops_equal;
			default:         o_branch_taken = 1'b0;
		endcase
	end

	// word offset, sign-extended
	assign br_offset       = {{(`MIPS_XLEN-18){i_imm[15]}}, i_imm, 2'b00};
	assign o_branch_target = i_pc4 + br_offset;

	// region jump keeps the top nibble of pc4
	assign o_jump_target = (o_jump_sel == mips_pkg::JMP_REG) ? cmp_rs :
		{i_pc4[`MIPS_XLEN-1 -: 4], i_index, 2'b00};

endmodule

// ==== hw/decode/id_main_ctrl.sv ====
// main control decoder, turns opcode and function code into execute, memory and writeback control
module id_main_ctrl (
	input  mips_pkg::opcode_e i_opcode,
	input  mips_pkg::funct_e  i_funct,
	output mips_pkg::alu_op_e o_alu_op,
	output logic              o_alu_src,
	output logic              o_reg_dst,
	output logic              o_mem_read,
	output logic              o_mem_write,
	output mips_pkg::load_e   o_load_width,
	output logic              o_mem_to_reg,
	output logic              o_reg_write,
	output logic              o_link,
	output logic              o_sign_ext
);

	always_comb begin
		// inactive defaults, also what an unknown opcode gets
		o_alu_op     = mips_pkg::ALU_ADD;
		o_alu_src    = 1'b0;
		o_reg_dst    = 1'b0;
		o_mem_read   = 1'b0;
		o_mem_write  = 1'b0;
		o_load_width = mips_pkg::LD_WORD;
		o_mem_to_reg = 1'b0;
		o_reg_write  = 1'b0;
		o_link       = 1'b0;
		o_sign_ext   = 1'b1;

		case (i_opcode)
			// ================================================
			// register-register group
			// ================================================
			mips_pkg::OP_RTYPE: begin
				o_reg_dst   = 1'b1;
				o_reg_write = 1'b1;
				case (i_funct)
					mips_pkg::F_ADD:  o_alu_op = mips_pkg::ALU_ADD;
					mips_pkg::F_ADDU: o_alu_op = mips_pkg::ALU_ADDU;
					mips_pkg::F_SUB:  o_alu_op = mips_pkg::ALU_SUB;
					mips_pkg::F_SUBU: o_alu_op = mips_pkg::ALU_SUBU;
					mips_pkg::F_AND:  o_alu_op = mips_pkg::ALU_AND;
					mips_pkg::F_OR:   o_alu_op = mips_pkg::ALU_OR;
					mips_pkg::F_XOR:  o_alu_op = mips_pkg::ALU_XOR;
					mips_pkg::F_NOR:  o_alu_op = mips_pkg::ALU_NOR;
					mips_pkg::F_SLT:  o_alu_op = mips_pkg::ALU_SLT;
					mips_pkg::F_SLTU: o_alu_op = mips_pkg::ALU_SLTU;
					// jr only redirects the PC
					mips_pkg::F_JR:   o_reg_write = 1'b0;
					// jalr writes the return address into rd
					mips_pkg::F_JALR: o_link = 1'b1;
					default: begin
						o_reg_dst   = 1'b0;
						o_reg_write = 1'b0;
					end
				endcase
			end

			// ================================================
			// immediate group
			// ================================================
			mips_pkg::OP_ADDI, mips_pkg::OP_ADDIU, mips_pkg::OP_SLTI, mips_pkg::OP_LUI,
			mips_pkg::OP_ANDI, mips_pkg::OP_ORI, mips_pkg::OP_XORI: begin
				o_alu_src   = 1'b1;
				o_reg_write = 1'b1;
				case (i_opcode)
					mips_pkg::OP_ADDIU: o_alu_op = mips_pkg::ALU_ADDU;
					mips_pkg::OP_SLTI:  o_alu_op = mips_pkg::ALU_SLT;
					mips_pkg::OP_LUI:   o_alu_op = mips_pkg::ALU_LUI;
					mips_pkg::OP_ANDI:  o_alu_op = mips_pkg::ALU_AND;
					mips_pkg::OP_ORI:   o_alu_op = mips_pkg::ALU_OR;
					mips_pkg::OP_XORI:  o_alu_op = mips_pkg::ALU_XOR;
					default:            o_alu_op = mips_pkg::ALU_ADD;
				endcase
				// logical immediates are zero-extended
				o_sign_ext = !(i_opcode inside {mips_pkg::OP_ANDI, mips_pkg::OP_ORI,
					mips_pkg::OP_XORI});
			end

			// loads and stores, address is rs plus offset
			mips_pkg::OP_LW, mips_pkg::OP_LH, mips_pkg::OP_LB: begin
				o_alu_src    = 1'b1;
				o_mem_read   = 1'b1;
				o_mem_to_reg = 1'b1;
				o_reg_write  = 1'b1;
				if (i_opcode == mips_pkg::OP_LH) begin
					o_load_width = mips_pkg::LD_HALF;
				end else if (i_opcode == mips_pkg::OP_LB) begin
					o_load_width = mips_pkg::LD_BYTE;
				end
			end
			mips_pkg::OP_SW: begin
				o_alu_src   = 1'b1;
				o_mem_write = 1'b1;
			end

			// return address goes to the link register
			mips_pkg::OP_JAL: begin
				o_link      = 1'b1;
				o_reg_write = 1'b1;
			end
			default: begin
			end
		endcase
	end

endmodule

// ==== hw/decode/id_regfile.sv ====
// 32-entry register bank of the decode stage, two read ports with write-through, one write port
`include "mips_cfg.svh"

module id_regfile (
	input  logic                   i_clk,
	input  logic                   i_nrst,
	input  logic [`MIPS_RADDR-1:0] i_rs_addr,
	input  logic [`MIPS_RADDR-1:0] i_rt_addr,
	input  logic                   i_we,
	input  logic [`MIPS_RADDR-1:0] i_wd_addr,
	input  logic [`MIPS_XLEN-1:0]  i_wd_data,
	output logic [`MIPS_XLEN-1:0]  o_rs_data,
	output logic [`MIPS_XLEN-1:0]  o_rt_data
);

	logic [`MIPS_XLEN-1:0] regs [`MIPS_NREG];
	logic                  wr_en;

	// register 0 is hardwired, so writes to it are dropped
	assign wr_en = i_we && (i_wd_addr != '0);

	always_ff @(posedge i_clk or negedge i_nrst) begin
		if (!i_nrst) begin
			for (int i = 0; i < `MIPS_NREG; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[i_wd_addr] <= i_wd_data;
		end
	end

	// write-through: a pending write wins over the stored value
	assign o_rs_data = (wr_en && i_wd_addr == i_rs_addr) ? i_wd_data : regs[i_rs_addr];
	assign o_rt_data = (wr_en && i_wd_addr == i_rt_addr) ? i_wd_data : regs[i_rt_addr];

endmodule

// ==== common/mips_pkg.sv ====
// shared MIPS decode types, referenced by scoped name from the decode RTL and testbench
package mips_pkg;

	// primary opcode field, instr[31:26]
	typedef enum logic [5:0] {
		OP_RTYPE = 6'h00,
		OP_J     = 6'h02,
		OP_JAL   = 6'h03,
		OP_BEQ   = 6'h04,
		OP_BNE   = 6'h05,
		OP_ADDI  = 6'h08,
		OP_ADDIU = 6'h09,
		OP_SLTI  = 6'h0a,
		OP_ANDI  = 6'h0c,
		OP_ORI   = 6'h0d,
		OP_XORI  = 6'h0e,
		OP_LUI   = 6'h0f,
		OP_LB    = 6'h20,
		OP_LH    = 6'h21,
		OP_LW    = 6'h23,
		OP_SW    = 6'h2b
	} opcode_e;

	// function field of R-type, instr[5:0]
	typedef enum logic [5:0] {
		F_JR   = 6'h08,
		F_JALR = 6'h09,
		F_ADD  = 6'h20,
		F_ADDU = 6'h21,
		F_SUB  = 6'h22,
		F_SUBU = 6'h23,
		F_AND  = 6'h24,
		F_OR   = 6'h25,
		F_XOR  = 6'h26,
		F_NOR  = 6'h27,
		F_SLT  = 6'h2a,
		F_SLTU = 6'h2b
	} funct_e;

	typedef enum logic [5:0] {
		ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU, ALU_AND, ALU_OR,
		ALU_XOR, ALU_NOR, ALU_SLT, ALU_SLTU, ALU_LUI
	} alu_op_e;

	typedef enum logic [1:0] {JMP_NONE, JMP_TARGET, JMP_REG} jump_e;
	typedef enum logic [1:0] {BR_NONE, BR_EQ, BR_NE} branch_e;
	typedef enum logic [1:0] {LD_WORD, LD_HALF, LD_BYTE} load_e;

	// operand source picked by the execute stage
	typedef enum logic [2:0] {FWD_NONE, FWD_EX_ALU, FWD_MEM_ALU, FWD_MEM_LOAD} fwd_e;

endpackage

// ==== common/mips_cfg.svh ====
// width and size settings for the decode stage, pulled in with `include where needed
`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

// data path and address width
`define MIPS_XLEN 32

// register bank depth
`define MIPS_NREG 32

// bits needed to name one register
`define MIPS_RADDR 5

`endif
